// ==== design/foc_pkg.sv ====
package foc_pkg;

  localparam int DATA_W      = 16;
  localparam int FRAC_W      = 15;
  localparam int CORDIC_ITER = 16;
  localparam int CORDIC_W    = DATA_W + 2;  // headroom for the rotating vector
  localparam int OUT_LIM     = 4096;
  localparam int SAMPLE_LAT  = 24;

  // Q1.15 constants
  localparam logic signed [DATA_W-1:0] INV_SQRT3  = 16'sd18919;
  localparam logic signed [DATA_W-1:0] SQRT3_HALF = 16'sd28378;
  localparam logic signed [DATA_W-1:0] CORDIC_K   = 16'sd19898;  // 1/gain after 16 steps

  // atan(2^-i) with a full turn of 2^16, entry 0 rightmost
  localparam logic [CORDIC_ITER-1:0][DATA_W-1:0] ATAN_TAB = {
    16'd0,    16'd1,    16'd1,    16'd3,    16'd5,    16'd10,   16'd20,   16'd41,
    16'd81,   16'd163,  16'd326,  16'd651,  16'd1297, 16'd2555, 16'd4836, 16'd8192
  };

  typedef logic signed [DATA_W-1:0] q15_t;

  typedef struct packed {
    logic [DATA_W-1:0] angle;
    q15_t              i_a;
    q15_t              i_b;
    q15_t              i_c;
    q15_t              q_target;
    logic [DATA_W-1:0] period_top;
  } sample_t;

  typedef struct packed {
    q15_t sin;
    q15_t cos;
  } sincos_t;

  typedef struct packed {
    q15_t d;
    q15_t q;
  } dq_t;

  typedef struct packed {
    q15_t a;
    q15_t b;
    q15_t c;
  } abc_t;

  typedef struct packed {
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] c;
  } duty_t;

  typedef struct packed {
    logic wen;
    logic axis;  // 0 d, 1 q
    logic addr;  // 0 kp, 1 ki
    q15_t data;
  } pi_cfg_t;

  typedef struct packed {
    logic a;
    logic b;
    logic c;
  } pwm_t;

  function automatic q15_t sat16(input logic signed [39:0] v);
    if (v > 40'sd32767) return 16'sh7fff;
    if (v < -40'sd32768) return 16'sh8000;
    return v[DATA_W-1:0];
  endfunction

endpackage

// ==== design/sincos_cordic.sv ====
module sincos_cordic (
  input  logic             clk,
  input  logic             rstb,
  input  logic             start_i,
  input  logic [15:0]      angle_i,
  output foc_pkg::sincos_t sincos_o,
  output logic             done_o
);
  import foc_pkg::*;

  logic signed [CORDIC_W-1:0] x_r, y_r, z_r;
  logic signed [CORDIC_W-1:0] x_in, y_in, z_in;
  logic signed [CORDIC_W-1:0] x_sh, y_sh, atan_v;
  logic signed [CORDIC_W-1:0] x_nx, y_nx, z_nx;
  logic [4:0] iter_r;
  logic [3:0] sh;
  logic       busy_r;
  logic       neg_r;
  logic       flip;
  logic       last;

  // second and third quadrant: rotate by a half turn, negate both results
  assign flip = angle_i[15] ^ angle_i[14];
  assign last = busy_r && (iter_r == 5'(CORDIC_ITER));

  always_comb begin
    if (start_i) begin
      x_in = CORDIC_W'(CORDIC_K);
      y_in = '0;
      z_in = CORDIC_W'($signed(angle_i ^ {flip, 15'd0}));  // now within +-quarter turn
      sh   = 4'd0;
    end else begin
      x_in = x_r;
      y_in = y_r;
      z_in = z_r;
      sh   = iter_r[3:0];
    end
    x_sh   = x_in >>> sh;
    y_sh   = y_in >>> sh;
    atan_v = CORDIC_W'(ATAN_TAB[sh]);
    if (z_in[CORDIC_W-1]) begin  // residual negative
      x_nx = x_in + y_sh;
      y_nx = y_in - x_sh;
      z_nx = z_in + atan_v;
    end else begin
      x_nx = x_in - y_sh;
      y_nx = y_in + x_sh;
      z_nx = z_in - atan_v;
    end
  end

  // first micro-rotation happens on the start edge itself
  always_ff @(posedge clk) begin
    if (start_i || (busy_r && !last)) begin
      x_r <= x_nx;
      y_r <= y_nx;
      z_r <= z_nx;
    end
    if (last) begin
      sincos_o.cos <= sat16(40'(neg_r ? -x_r : x_r));
      sincos_o.sin <= sat16(40'(neg_r ? -y_r : y_r));
    end
  end

  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      busy_r <= 1'b0;
      iter_r <= '0;
      neg_r  <= 1'b0;
      done_o <= 1'b0;
    end else begin
      done_o <= last;
      if (start_i) begin
        busy_r <= 1'b1;
        iter_r <= 5'd1;
        neg_r  <= flip;
      end else if (last) begin
        busy_r <= 1'b0;
      end else if (busy_r) begin
        iter_r <= iter_r + 5'd1;
      end
    end
  end

endmodule

// ==== design/forward_transform.sv ====
module forward_transform (
  input  logic             clk,
  input  logic             rstb,
  input  logic             clarke_start_i,
  input  logic             park_start_i,
  input  foc_pkg::abc_t    phase_i,
  input  foc_pkg::sincos_t sincos_i,
  output foc_pkg::dq_t     dq_o,
  output logic             done_o
);
  import foc_pkg::*;

  q15_t alpha_r;
  q15_t beta_r;
  logic signed [DATA_W+1:0] ab2;  // a + 2b
  logic signed [33:0]       beta_p;
  logic signed [31:0]       ac_r, bs_r, bc_r, as_r;
  logic signed [32:0]       d_sum, q_sum;
  logic                     park_s1_r;

  assign ab2    = phase_i.a + phase_i.b + phase_i.b;
  assign beta_p = ab2 * INV_SQRT3;

  assign d_sum = ac_r + bs_r;
  assign q_sum = bc_r - as_r;

  always_ff @(posedge clk) begin
    if (clarke_start_i) begin
      alpha_r <= phase_i.a;
      beta_r  <= sat16(40'(beta_p >>> FRAC_W));
    end
    // park: products first, sum on the next edge
    if (park_start_i) begin
      ac_r <= alpha_r * sincos_i.cos;
      bs_r <= beta_r * sincos_i.sin;
      bc_r <= beta_r * sincos_i.cos;
      as_r <= alpha_r * sincos_i.sin;
    end
    if (park_s1_r) begin
      dq_o.d <= sat16(40'(d_sum >>> FRAC_W));
      dq_o.q <= sat16(40'(q_sum >>> FRAC_W));
    end
  end

  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      park_s1_r <= 1'b0;
      done_o    <= 1'b0;
    end else begin
      park_s1_r <= park_start_i;
      done_o    <= park_s1_r;
    end
  end

endmodule

// ==== design/pi_regulator.sv ====
module pi_regulator (
  input  logic          clk,
  input  logic          rstb,
  input  logic          cfg_wen_i,
  input  logic          cfg_addr_i,
  input  foc_pkg::q15_t cfg_data_i,
  input  logic          start_i,
  input  foc_pkg::q15_t target_i,
  input  foc_pkg::q15_t meas_i,
  output foc_pkg::q15_t out_o,
  output logic          done_o
);
  import foc_pkg::*;

  q15_t kp_r;
  q15_t ki_r;
  q15_t integ_r;
  q15_t integ_nx;
  q15_t out_nx;
  logic signed [DATA_W:0] err;
  logic signed [32:0]     p_term, i_term;
  logic signed [33:0]     integ_sum, out_sum;

  function automatic q15_t clamp_lim(input logic signed [33:0] v);
    if (v > OUT_LIM) return q15_t'(OUT_LIM);
    if (v < -OUT_LIM) return q15_t'(-OUT_LIM);
    return v[DATA_W-1:0];
  endfunction

  assign err    = target_i - meas_i;
  assign p_term = err * kp_r;
  assign i_term = err * ki_r;

  // integrator is clamped before it feeds the output sum
  assign integ_sum = (i_term >>> FRAC_W) + integ_r;
  assign integ_nx  = clamp_lim(integ_sum);
  assign out_sum   = (p_term >>> FRAC_W) + integ_nx;
  assign out_nx    = clamp_lim(out_sum);

  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      kp_r    <= '0;
      ki_r    <= '0;
      integ_r <= '0;
      out_o   <= '0;
      done_o  <= 1'b0;
    end else begin
      if (cfg_wen_i) begin
        if (cfg_addr_i) begin
          ki_r <= cfg_data_i;
        end else begin
          kp_r <= cfg_data_i;
        end
      end
      done_o <= start_i;
      if (start_i) begin
        integ_r <= integ_nx;
        out_o   <= out_nx;
      end
    end
  end

endmodule

// ==== design/inverse_transform.sv ====
module inverse_transform (
  input  logic             clk,
  input  logic             rstb,
  input  logic             start_i,
  input  foc_pkg::dq_t     dq_i,
  input  foc_pkg::sincos_t sincos_i,
  output foc_pkg::abc_t    phase_o,
  output logic             done_o
);
  import foc_pkg::*;

  q15_t alpha_r;
  q15_t beta_r;
  q15_t b_val;
  logic signed [32:0]       alpha_sum, beta_sum;
  logic signed [31:0]       beta_k;
  logic signed [33:0]       b_full;
  logic signed [DATA_W+1:0] c_full;
  logic                     s1_r;

  // inverse park
  assign alpha_sum = dq_i.d * sincos_i.cos - dq_i.q * sincos_i.sin;
  assign beta_sum  = dq_i.d * sincos_i.sin + dq_i.q * sincos_i.cos;

  // inverse clarke, c from the saturated b
  assign beta_k = beta_r * SQRT3_HALF;
  assign b_full = (beta_k >>> FRAC_W) - (alpha_r >>> 1);
  assign b_val  = sat16(40'(b_full));
  assign c_full = -alpha_r - b_val;

  always_ff @(posedge clk) begin
    if (start_i) begin
      alpha_r <= sat16(40'(alpha_sum >>> FRAC_W));
      beta_r  <= sat16(40'(beta_sum >>> FRAC_W));
    end
    if (s1_r) begin
      phase_o.a <= alpha_r;
      phase_o.b <= b_val;
      phase_o.c <= sat16(40'(c_full));
    end
  end

  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      s1_r   <= 1'b0;
      done_o <= 1'b0;
    end else begin
      s1_r   <= start_i;
      done_o <= s1_r;
    end
  end

endmodule

// ==== design/pwm_modulator.sv ====
module pwm_modulator (
  input  logic           clk,
  input  logic           rstb,
  input  logic           start_i,
  input  foc_pkg::abc_t  phase_i,
  input  logic [15:0]    period_top_i,
  output foc_pkg::duty_t duty_o,
  output logic           done_o,
  output foc_pkg::pwm_t  pwm_o
);
  import foc_pkg::*;

  logic [2:0][DATA_W-1:0]   v_vec;
  logic [2:0][2*DATA_W-1:0] prod_r;
  logic [2:0][DATA_W-1:0]   duty_nx;
  logic [2:0][DATA_W-1:0]   duty_act_r;
  logic [2:0]               cmp;
  logic [DATA_W-1:0]        cnt_r;
  logic [DATA_W-1:0]        per_r;
  logic [DATA_W-1:0]        per_pend_r;
  logic                     pend_r;
  logic                     s1_r;
  logic                     wrap;

  assign v_vec = phase_i;  // index 2 is phase a

  always_comb begin
    for (int k = 0; k < 3; k++) begin
      duty_nx[k] = prod_r[k][2*DATA_W-1:DATA_W];
      cmp[k]     = cnt_r < duty_act_r[k];
    end
  end

  // zero period keeps the carrier parked at 0
  assign wrap = (per_r == '0) || (cnt_r == per_r - 1'b1);

  always_ff @(posedge clk) begin
    if (start_i) begin
      for (int k = 0; k < 3; k++) begin
        // flipping the sign bit adds 32768
        prod_r[k] <= {~v_vec[k][DATA_W-1], v_vec[k][DATA_W-2:0]} * period_top_i;
      end
    end
  end

  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      s1_r       <= 1'b0;
      done_o     <= 1'b0;
      duty_o     <= '0;
      per_pend_r <= '0;
      pend_r     <= 1'b0;
      cnt_r      <= '0;
      per_r      <= '0;
      duty_act_r <= '0;
      pwm_o      <= '0;
    end else begin
      s1_r   <= start_i;
      done_o <= s1_r;
      if (wrap) begin
        cnt_r <= '0;
        if (pend_r) begin
          per_r      <= per_pend_r;
          duty_act_r <= duty_o;
          pend_r     <= 1'b0;
        end
      end else begin
        cnt_r <= cnt_r + 1'b1;
      end
      if (s1_r) begin
        duty_o     <= duty_t'(duty_nx);
        per_pend_r <= period_top_i;
        pend_r     <= 1'b1;  // a new set wins over a clear at the same wrap
      end
      pwm_o <= pwm_t'(cmp);
    end
  end

endmodule

// ==== design/foc_top.sv ====
module foc_top (
  input  logic             clk,
  input  logic             rstb,
  input  foc_pkg::sample_t sample_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  foc_pkg::pi_cfg_t cfg_i,
  output foc_pkg::duty_t   duty_o,
  output logic             done_o,
  output foc_pkg::pwm_t    pwm_o
);
  import foc_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_CORDIC,
    S_PARK,
    S_PI,
    S_INV,
    S_PWM
  } state_t;

  state_t  state_r;
  sample_t sample_r;
  logic    start_r;
  logic    accept;

  sincos_t sincos;
  abc_t    i_abc;
  dq_t     i_dq;
  q15_t    v_d;
  q15_t    v_q;
  dq_t     v_dq;
  abc_t    v_abc;

  logic cordic_done;
  logic park_done;
  logic pi_d_done;
  logic pi_q_done;
  logic inv_done;
  logic park_start;
  logic pi_start;
  logic inv_start;
  logic pwm_start;

  assign accept = ready_o && valid_i;

  // each strobe is the previous block's done, qualified by the waiting state
  assign park_start = (state_r == S_CORDIC) && cordic_done;
  assign pi_start   = (state_r == S_PARK) && park_done;
  assign inv_start  = (state_r == S_PI) && pi_d_done && pi_q_done;
  assign pwm_start  = (state_r == S_INV) && inv_done;

  assign i_abc = '{a: sample_r.i_a, b: sample_r.i_b, c: sample_r.i_c};
  assign v_dq  = '{d: v_d, q: v_q};

  always_ff @(posedge clk) begin
    if (accept) begin
      sample_r <= sample_i;
    end
  end

  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      state_r <= S_IDLE;
      ready_o <= 1'b1;
      start_r <= 1'b0;
    end else begin
      start_r <= 1'b0;
      case (state_r)
        S_IDLE: begin
          if (accept) begin
            start_r <= 1'b1;  // cordic and clarke together
            ready_o <= 1'b0;
            state_r <= S_CORDIC;
          end
        end
        S_CORDIC: if (park_start) state_r <= S_PARK;
        S_PARK:   if (pi_start) state_r <= S_PI;
        S_PI:     if (inv_start) state_r <= S_INV;
        S_INV:    if (pwm_start) state_r <= S_PWM;
        S_PWM: begin
          if (done_o) begin
            ready_o <= 1'b1;
            state_r <= S_IDLE;
          end
        end
        default: state_r <= S_IDLE;
      endcase
    end
  end

  sincos_cordic cordic_inst (
    .clk      (clk),
    .rstb     (rstb),
    .start_i  (start_r),
    .angle_i  (sample_r.angle),
    .sincos_o (sincos),
    .done_o   (cordic_done)
  );

  forward_transform fwd_inst (
    .clk            (clk),
    .rstb           (rstb),
    .clarke_start_i (start_r),
    .park_start_i   (park_start),
    .phase_i        (i_abc),
    .sincos_i       (sincos),
    .dq_o           (i_dq),
    .done_o         (park_done)
  );

  pi_regulator pi_d (
    .clk        (clk),
    .rstb       (rstb),
    .cfg_wen_i  (cfg_i.wen && !cfg_i.axis),
    .cfg_addr_i (cfg_i.addr),
    .cfg_data_i (cfg_i.data),
    .start_i    (pi_start),
    .target_i   ('0),  // no field weakening
    .meas_i     (i_dq.d),
    .out_o      (v_d),
    .done_o     (pi_d_done)
  );

  pi_regulator pi_q (
    .clk        (clk),
    .rstb       (rstb),
    .cfg_wen_i  (cfg_i.wen && cfg_i.axis),
    .cfg_addr_i (cfg_i.addr),
    .cfg_data_i (cfg_i.data),
    .start_i    (pi_start),
    .target_i   (sample_r.q_target),
    .meas_i     (i_dq.q),
    .out_o      (v_q),
    .done_o     (pi_q_done)
  );

  inverse_transform inv_inst (
    .clk      (clk),
    .rstb     (rstb),
    .start_i  (inv_start),
    .dq_i     (v_dq),
    .sincos_i (sincos),
    .phase_o  (v_abc),
    .done_o   (inv_done)
  );

  pwm_modulator pwm_inst (
    .clk          (clk),
    .rstb         (rstb),
    .start_i      (pwm_start),
    .phase_i      (v_abc),
    .period_top_i (sample_r.period_top),
    .duty_o       (duty_o),
    .done_o       (done_o),
    .pwm_o        (pwm_o)
  );

endmodule

// ==== sim/foc_props.sv ====
module foc_props (
  input logic          clk,
  input logic          rstb,
  input logic          valid_i,
  input logic          ready_i,
  input logic          done_i,
  input foc_pkg::pwm_t pwm_i,
  input logic [15:0]   per_i
);
  timeunit 1ns;
  timeprecision 100ps;
  import foc_pkg::*;

  done_one_cycle: assert property (@(posedge clk) disable iff (!rstb)
    done_i |=> !done_i)
    else $error("done_o held longer than one cycle");

  // ready comes back right after the done pulse
  ready_after_done: assert property (@(posedge clk) disable iff (!rstb)
    done_i |-> !ready_i ##1 ready_i)
    else $error("ready_o did not rise one cycle after done_o");

  accept_to_done: assert property (@(posedge clk) disable iff (!rstb)
    (valid_i && ready_i) |-> ##(SAMPLE_LAT + 1) done_i)
    else $error("done_o missing at the fixed latency");

  done_from_accept: assert property (@(posedge clk) disable iff (!rstb)
    done_i |-> $past(valid_i && ready_i, SAMPLE_LAT + 1))
    else $error("done_o without an accepted sample at the fixed latency");

  pwm_idle: assert property (@(posedge clk) disable iff (!rstb)
    (per_i == '0) |=> (pwm_i == '0))
    else $error("pwm_o active with a zero period");

endmodule

// ==== sim/foc_tb.sv ====
module foc_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import foc_pkg::*;

  localparam int CLK_HALF = 10;

  typedef struct {
    bit      is_gain;
    pi_cfg_t cfg;
    sample_t smp;
    duty_t   exp;
  } rec_t;

  logic    clk = 1'b0;
  logic    rstb;
  sample_t sample_i;
  logic    valid_i;
  logic    ready_o;
  pi_cfg_t cfg_i;
  duty_t   duty_o;
  logic    done_o;
  pwm_t    pwm_o;

  rec_t        recs[$];
  int          n_samples;
  int          max_period;
  logic [31:0] lfsr_q;
  bit          loaded;

  foc_top foc_top_inst (
    .clk      (clk),
    .rstb     (rstb),
    .sample_i (sample_i),
    .valid_i  (valid_i),
    .ready_o  (ready_o),
    .cfg_i    (cfg_i),
    .duty_o   (duty_o),
    .done_o   (done_o),
    .pwm_o    (pwm_o)
  );

  bind foc_top foc_props props_inst (
    .clk     (clk),
    .rstb    (rstb),
    .valid_i (valid_i),
    .ready_i (ready_o),
    .done_i  (done_o),
    .pwm_i   (pwm_o),
    .per_i   (pwm_inst.per_r)
  );

  always #CLK_HALF clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int k = 0; k < n; k++) begin
      v = (v << 1) | int'(lfsr_q[0]);
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_duty(input duty_t got, input duty_t exp, input int idx);
    if (got !== exp) begin
      fail_now($sformatf("Mismatch at %0t: sample %0d duty got %h %h %h expected %h %h %h",
                         $time, idx, got.a, got.b, got.c, exp.a, exp.b, exp.c));
    end
  endtask

  task automatic check_pwm(input pwm_t got, input pwm_t exp, input int idx, input int step);
    if (got !== exp) begin
      fail_now($sformatf("Mismatch at %0t: sample %0d carrier step %0d pwm got %b expected %b",
                         $time, idx, step, got, exp));
    end
  endtask

  task automatic read_trace();
    int          fd;
    int          n;
    string       line;
    logic [15:0] f0, f1, f2, f3, f4, f5, f6, f7, f8;
    rec_t        r;
    fd = $fopen("sim/foc_trace.txt", "r");
    if (fd == 0) fail_now("could not open the trace file sim/foc_trace.txt");
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n == 0 || line.len() <= 1 || line.getc(0) == "#") continue;
      r = '{default: '0};
      if ($sscanf(line, "W %h %h %h", f0, f1, f2) == 3) begin
        r.is_gain  = 1'b1;
        r.cfg.wen  = 1'b1;
        r.cfg.axis = f0[0];
        r.cfg.addr = f1[0];
        r.cfg.data = f2;
      end else if ($sscanf(line, "%h %h %h %h %h %h %h %h %h",
                           f0, f1, f2, f3, f4, f5, f6, f7, f8) == 9) begin
        r.smp = '{angle: f0, i_a: f1, i_b: f2, i_c: f3, q_target: f4, period_top: f5};
        r.exp = '{a: f6, b: f7, c: f8};
        n_samples++;
        if (int'(f5) > max_period) max_period = int'(f5);
      end else begin
        fail_now($sformatf("trace line could not be read: %s", line));
      end
      recs.push_back(r);
    end
    $fclose(fd);
    loaded = 1'b1;
  endtask

  task automatic write_gain(input pi_cfg_t c);
    @(posedge clk);
    cfg_i <= c;
    @(posedge clk);
    cfg_i <= '0;
  endtask

  task automatic run_sample(input sample_t s, input duty_t exp, input int idx);
    int lat;
    @(posedge clk);
    sample_i <= s;
    valid_i  <= 1'b1;
    @(negedge clk);
    if (ready_o !== 1'b1) fail_now("DUT not ready for a new sample while idle");
    @(posedge clk);
    sample_i <= sample_t'(~s);  // other data while busy, must be ignored
    lat = 0;
    @(negedge clk);
    while (done_o !== 1'b1) begin
      if (lat > 4 * SAMPLE_LAT) fail_now("done_o never arrived after an accepted sample");
      @(posedge clk);
      lat++;
      @(negedge clk);
    end
    if (lat != SAMPLE_LAT) begin
      fail_now($sformatf("Mismatch at %0t: sample %0d latency got %0d expected %0d",
                         $time, idx, lat, SAMPLE_LAT));
    end
    check_duty(duty_o, exp, idx);
    @(posedge clk);
    valid_i  <= 1'b0;
    sample_i <= '0;
  endtask

  // one carrier period, phase k high while the count is below its duty
  task automatic check_carrier(input int per, input int prev_per, input duty_t exp,
                               input int idx);
    int         d[3];
    int         ref_k;
    int         waited;
    logic [2:0] lv;
    logic       prev_lvl;
    pwm_t       want;
    d[0] = int'(exp.a);
    d[1] = int'(exp.b);
    d[2] = int'(exp.c);
    ref_k = 0;
    for (int k = 1; k < 3; k++) begin
      if (d[k] > d[ref_k]) ref_k = k;
    end
    repeat (prev_per + 3) @(posedge clk);  // new set loaded by now
    @(negedge clk);
    if (d[ref_k] > 0) begin
      lv = pwm_o;
      prev_lvl = lv[2-ref_k];
      waited = 0;
      forever begin
        @(negedge clk);
        lv = pwm_o;
        if (!prev_lvl && lv[2-ref_k]) break;
        prev_lvl = lv[2-ref_k];
        waited++;
        if (waited > 2 * per + 4) fail_now("no carrier wrap seen on the PWM outputs");
      end
    end
    for (int j = 0; j < per; j++) begin
      want.a = (j < d[0]);
      want.b = (j < d[1]);
      want.c = (j < d[2]);
      check_pwm(pwm_o, want, idx, j);
      @(negedge clk);
    end
  endtask

  initial begin
    int limit;
    wait (loaded);
    limit = (n_samples + 2) * (SAMPLE_LAT + 8 + 3 * max_period);
    repeat (limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", limit);
    $display("Test FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int prev_per;
    int gap;
    rstb       = 1'b0;
    valid_i    = 1'b0;
    sample_i   = '0;
    cfg_i      = '0;
    n_samples  = 0;
    max_period = 0;
    prev_per   = 0;
    lfsr_q     = 32'h5db4_0d25;
    read_trace();
    repeat (4) @(posedge clk);
    rstb <= 1'b1;
    @(negedge clk);
    if (ready_o !== 1'b1 || done_o !== 1'b0 || pwm_o !== 3'b000) begin
      fail_now("outputs not in their idle state after reset");
    end
    foreach (recs[i]) begin
      if (recs[i].is_gain) begin
        write_gain(recs[i].cfg);
      end else begin
        run_sample(recs[i].smp, recs[i].exp, i);
        check_carrier(int'(recs[i].smp.period_top), prev_per, recs[i].exp, i);
        prev_per = int'(recs[i].smp.period_top);
        gap = take_bits(3);  // 0 to 7 idle cycles
        repeat (gap) @(posedge clk);
      end
    end
    $display("Test OK");
    $finish;
  end

endmodule

// ==== sim.f ====
design/foc_pkg.sv
design/sincos_cordic.sv
design/forward_transform.sv
design/pi_regulator.sv
design/inverse_transform.sv
design/pwm_modulator.sv
design/foc_top.sv
sim/foc_props.sv
sim/foc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the FOC testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -Wno-fatal -f sim.f --top-module foc_tb -o foc_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/foc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "Test OK" "$LOG"; then
  echo "no pass line found in $LOG"
  exit 1
fi
exit 0

// ==== sim/foc_trace.txt ====
# W axis addr data : gain write, axis 0=d 1=q, addr 0=kp 1=ki, data Q1.15 hex
# angle i_a i_b i_c q_target period_top exp_a exp_b exp_c : one sample, all hex
# zero gains, every quadrant, outputs sit at mid duty
0000 0000 0000 0000 0000 000f 0007 0007 0007
4000 03e8 fe0c fe0c 0800 0014 000a 000a 000a
8000 0200 ff00 ff00 0100 0021 0010 0010 0010
c000 0010 fff0 0000 0000 0011 0008 0008 0008
# q proportional gain only
W 1 0 4000
0000 0000 0000 0000 2000 003f 001f 0022 001c
# q integral gain, integrator builds up over equal samples
W 1 1 2000
0000 0000 0000 0000 0800 0065 0032 0034 0030
0000 0000 0000 0000 0800 0065 0032 0035 002f
0000 0000 0000 0000 0800 0065 0032 0035 002f
# large target drives both clamps
2000 0000 0000 0000 7000 0065 002e 0038 0030
6000 0000 0000 0000 7000 0065 002e 0030 0038
# integrator frozen at the clamp, d proportional gain on
W 1 1 0000
W 0 0 4000
0000 0fa0 f830 f830 0000 0065 002f 0039 002e
8000 f448 05dc 05dc 0000 0065 0034 002b 0036
c000 0000 07d0 f830 0000 0065 0038 002d 0030
